// File: design/ex_params.svh
// Fixed widths for the scalar execute stage
// All widths follow the 32 bit integer instruction set and are not meant
// to be overridden per instance
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Operand and result width
`define EX_DATA_W 32

// Register file address width, covers integer and extra registers
`define EX_REG_ADDR_W 6

// Shift amount taken from the low bits of operand b
`define EX_SHAMT_W 5

// Wait cycles of a high product multiply, one per 16 bit half of operand a
`define EX_MULH_STEPS 2

`endif

// File: design/ex_pkg.sv
// Shared types of the execute stage
// Opcode encodings are internal to this stage and must match the decoder
`include "ex_params.svh"

package ex_pkg;

  // Operand and result word
  typedef logic [`EX_DATA_W-1:0] data_t;

  // Register file address
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

  // ALU opcodes, compare group drives the branch decision
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB,
    ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Multiplier opcodes
  typedef enum logic [1:0] {
    MUL_LO, MUL_H, MUL_HSU, MUL_HU
  } mult_op_e;

  // Multiplier FSM states
  typedef enum logic [1:0] {
    MS_IDLE, MS_STEP_LO, MS_STEP_HI, MS_DONE
  } mult_state_e;

endpackage

// File: design/ex_alu.sv
// Integer ALU of the execute stage, purely combinational
// One adder serves ADD, SUB and all compares
// Compare opcodes return the condition as a 0/1 word on result_o as well
`timescale 1ns/100ps
`include "ex_params.svh"

module ex_alu (
  input  ex_pkg::alu_op_e alu_operator_i,
  input  ex_pkg::data_t   operand_a_i,
  input  ex_pkg::data_t   operand_b_i,
  output ex_pkg::data_t   result_o,
  output logic            cmp_result_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////////////////////

  logic                    adder_sub;
  ex_pkg::data_t           adder_b;
  logic [`EX_DATA_W:0]     adder_full;
  ex_pkg::data_t           adder_sum;
  logic                    adder_carry;

  // Everything except ADD subtracts
  assign adder_sub = (alu_operator_i != ex_pkg::ALU_ADD);

  // Two's complement of b via inversion plus carry in
  assign adder_b = adder_sub ? ~operand_b_i : operand_b_i;

  assign adder_full  = {1'b0, operand_a_i} + {1'b0, adder_b}
                       + {{`EX_DATA_W{1'b0}}, adder_sub};
  assign adder_sum   = adder_full[`EX_DATA_W-1:0];
  assign adder_carry = adder_full[`EX_DATA_W];

  ////////////////////////////////////////////////////////////////////////////
  // Compare flags
  ////////////////////////////////////////////////////////////////////////////

  logic is_equal;
  logic less_s;
  logic less_u;

  assign is_equal = (adder_sum == '0);

  // No carry out of a - b means a borrow, so a < b unsigned
  assign less_u = ~adder_carry;

  // Same signs cannot overflow, take sign of difference
  // Different signs, the negative operand is smaller
  assign less_s = (operand_a_i[`EX_DATA_W-1] == operand_b_i[`EX_DATA_W-1])
                  ? adder_sum[`EX_DATA_W-1]
                  : operand_a_i[`EX_DATA_W-1];

  ////////////////////////////////////////////////////////////////////////////
  // Branch condition
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_operator_i)
      ex_pkg::ALU_EQ:  cmp_result_o = is_equal;
      ex_pkg::ALU_NE:  cmp_result_o = ~is_equal;
      ex_pkg::ALU_LT:  cmp_result_o = less_s;
      ex_pkg::ALU_GE:  cmp_result_o = ~less_s;
      ex_pkg::ALU_LTU: cmp_result_o = less_u;
      ex_pkg::ALU_GEU: cmp_result_o = ~less_u;
      // Not a branch compare
      default:         cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////////////////////

  logic [`EX_SHAMT_W-1:0] shamt;

  // Only the low bits of b count as shift amount
  assign shamt = operand_b_i[`EX_SHAMT_W-1:0];

  always_comb begin
    case (alu_operator_i)
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB:  result_o = adder_sum;
      ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      ex_pkg::ALU_SRA:  result_o = ex_pkg::data_t'($signed(operand_a_i) >>> shamt);
      ex_pkg::ALU_SLT:  result_o = {{(`EX_DATA_W-1){1'b0}}, less_s};
      ex_pkg::ALU_SLTU: result_o = {{(`EX_DATA_W-1){1'b0}}, less_u};
      // Branch compares, condition as 0/1
      default:          result_o = {{(`EX_DATA_W-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

// File: design/ex_mult.sv
// Integer multiplier of the execute stage
// MUL_LO is combinational, ready_o stays high
// High products take the enable cycle plus one cycle per step, then wait
// in MS_DONE with ready_o high until ex_ready_i
// Operands are read straight from the inputs, the ID side must hold them
// until the stage is ready
`timescale 1ns/100ps
`include "ex_params.svh"

module ex_mult (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,
  input  ex_pkg::mult_op_e operator_i,
  input  ex_pkg::data_t    op_a_i,
  input  ex_pkg::data_t    op_b_i,
  input  logic             ex_ready_i,
  output ex_pkg::data_t    result_o,
  output logic             ready_o,
  output logic             multicycle_o
);

  // Half of operand a handled per step
  localparam int HALF_W = `EX_DATA_W / `EX_MULH_STEPS;
  // Signed half times sign extended b
  localparam int PP_W   = HALF_W + `EX_DATA_W + 2;
  // 33 by 33 bit signed product
  localparam int ACC_W  = 2 * `EX_DATA_W + 2;

  ex_pkg::mult_state_e state_q;
  ex_pkg::mult_state_e state_d;

  logic                       high_op;
  logic                       sign_a;
  logic                       sign_b;
  logic signed [`EX_DATA_W:0] a_ext;
  logic signed [`EX_DATA_W:0] b_ext;
  logic signed [HALF_W:0]     a_part;
  logic signed [PP_W-1:0]     partial;
  logic [ACC_W-1:0]           acc_q;
  ex_pkg::data_t              prod_lo;

  ////////////////////////////////////////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////////////////////////////////////////

  assign high_op = (operator_i != ex_pkg::MUL_LO);

  // MULH signs both, MULHSU only a, MULHU none
  assign sign_a = (operator_i == ex_pkg::MUL_H) || (operator_i == ex_pkg::MUL_HSU);
  assign sign_b = (operator_i == ex_pkg::MUL_H);

  assign a_ext = {sign_a & op_a_i[`EX_DATA_W-1], op_a_i};
  assign b_ext = {sign_b & op_b_i[`EX_DATA_W-1], op_b_i};

  // Low half is unsigned, upper half carries the sign of a
  assign a_part = (state_q == ex_pkg::MS_STEP_HI)
                  ? a_ext[`EX_DATA_W:HALF_W]
                  : {1'b0, a_ext[HALF_W-1:0]};

  // One shared partial product multiplier for both steps
  assign partial = a_part * b_ext;

  // Low word, truncation gives the same bits for any signedness
  assign prod_lo = op_a_i * op_b_i;

  ////////////////////////////////////////////////////////////////////////////
  // Step FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ex_pkg::MS_IDLE: begin
        if (enable_i && high_op) begin
          state_d = ex_pkg::MS_STEP_LO;
        end
      end
      ex_pkg::MS_STEP_LO: state_d = ex_pkg::MS_STEP_HI;
      ex_pkg::MS_STEP_HI: state_d = ex_pkg::MS_DONE;
      // Hold the result until the stage moves on
      ex_pkg::MS_DONE: begin
        if (ex_ready_i) begin
          state_d = ex_pkg::MS_IDLE;
        end
      end
      default: state_d = ex_pkg::MS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::MS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Accumulator
  always_ff @(posedge clk) begin
    if (state_q == ex_pkg::MS_STEP_LO) begin
      acc_q <= {{(ACC_W-PP_W){partial[PP_W-1]}}, partial};
    end else if (state_q == ex_pkg::MS_STEP_HI) begin
      // Upper partial weighs 2^HALF_W
      acc_q <= acc_q + {partial, {HALF_W{1'b0}}};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign result_o = (state_q == ex_pkg::MS_DONE) ? acc_q[2*`EX_DATA_W-1:`EX_DATA_W]
                                                 : prod_lo;

  // Busy from the enable cycle of a high product up to MS_DONE
  assign ready_o = (state_q == ex_pkg::MS_DONE)
                   || ((state_q == ex_pkg::MS_IDLE) && !(enable_i && high_op));

  assign multicycle_o = (state_q != ex_pkg::MS_IDLE);

endmodule

// File: design/ex_writeback.sv
// Writeback combiner of the execute stage
// Forwarding port is combinational, load port goes through the EX/WB register
// Load data is not registered, it follows lsu_rdata_i in the writeback cycle
// A branch in EX forces ready high but never valid
`timescale 1ns/100ps
`include "ex_params.svh"

module ex_writeback (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  input  ex_pkg::data_t     alu_result_i,
  input  ex_pkg::data_t     mult_result_i,
  input  ex_pkg::data_t     csr_rdata_i,
  input  logic              mult_ready_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  ex_pkg::data_t     lsu_rdata_i,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::data_t     regfile_alu_wdata_fw_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::data_t     regfile_wdata_wb_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  logic              units_ready;
  logic              stage_valid;
  logic              load_we;
  logic              we_q;
  ex_pkg::reg_addr_t waddr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stall logic
  ////////////////////////////////////////////////////////////////////////////

  // ALU is single cycle and always ready
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  assign stage_valid = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // Branches resolve in EX and need no writeback slot
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = stage_valid;

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB register for the load port
  ////////////////////////////////////////////////////////////////////////////

  // A faulting access never writes the register file
  assign load_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (stage_valid) begin
      we_q <= load_we;
    end else if (wb_ready_i) begin
      // WB takes a new entry but EX has none, flush the old one
      we_q <= 1'b0;
    end
  end

  // Address moves only with a captured write
  always_ff @(posedge clk) begin
    if (stage_valid && load_we) begin
      waddr_q <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = we_q;
  assign regfile_waddr_wb_o = waddr_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

// File: design/ex_stage.sv
// Scalar execute stage top level
// ID holds all inputs while ex_ready_o is low
// Jump target is operand c passed through, branch decision comes from the ALU
`timescale 1ns/100ps
`include "ex_params.svh"

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  // ALU
  input  logic              alu_en_i,
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::data_t     alu_operand_a_i,
  input  ex_pkg::data_t     alu_operand_b_i,
  input  ex_pkg::data_t     alu_operand_c_i,
  // Multiplier
  input  logic              mult_en_i,
  input  ex_pkg::mult_op_e  mult_operator_i,
  input  ex_pkg::data_t     mult_operand_a_i,
  input  ex_pkg::data_t     mult_operand_b_i,
  // CSR read
  input  logic              csr_access_i,
  input  ex_pkg::data_t     csr_rdata_i,
  // Destination registers from ID
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  // LSU status
  input  logic              lsu_en_i,
  input  ex_pkg::data_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  // Stall control
  input  logic              branch_in_ex_i,
  input  logic              wb_ready_i,
  // Forwarding port to ID
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::data_t     regfile_alu_wdata_fw_o,
  // Load write port into WB
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::data_t     regfile_wdata_wb_o,
  // To IF
  output ex_pkg::data_t     jump_target_o,
  output logic              branch_decision_o,
  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  ex_pkg::data_t alu_result;
  logic          alu_cmp_result;
  ex_pkg::data_t mult_result;
  logic          mult_ready;

  ////////////////////////////////////////////////////////////////////////////
  // ALU and branch outputs
  ////////////////////////////////////////////////////////////////////////////

  ex_alu alu0 (
    .alu_operator_i (alu_operator_i),
    .operand_a_i    (alu_operand_a_i),
    .operand_b_i    (alu_operand_b_i),
    .result_o       (alu_result),
    .cmp_result_o   (alu_cmp_result)
  );

  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ////////////////////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////////////////////

  // Stage ready releases the multiplier from MS_DONE
  ex_mult mult0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Writeback combiner and stall logic
  ////////////////////////////////////////////////////////////////////////////

  ex_writeback wb0 (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

// File: test/ex_stage_assertions.sv
// Protocol checks for the execute stage, bound into every ex_stage
// Assumes the ID side holds operands and enables while ex_ready_o is low
// The multicycle check assumes no branch override during a high product
`timescale 1ns/100ps
`include "ex_params.svh"

module ex_stage_assertions (
  input logic             clk,
  input logic             rst_n,
  input logic             ex_valid_o,
  input logic             ex_ready_o,
  input logic             mult_multicycle_o,
  input logic             mult_en_i,
  input ex_pkg::mult_op_e mult_operator_i,
  input logic             branch_in_ex_i,
  input logic             wb_ready_i,
  input logic             regfile_we_wb_o,
  input ex_pkg::data_t    regfile_alu_wdata_fw_o
);

  logic high_start;

  // Count of failed properties
  int fail_count = 0;

  // High product leaving MS_IDLE
  assign high_start = mult_en_i && (mult_operator_i != ex_pkg::MUL_LO)
                      && !mult_multicycle_o && !branch_in_ex_i;

  // Valid with a busy multiplier only after all its steps
  valid_mult_done: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o |-> (!mult_multicycle_o || $past(mult_multicycle_o, `EX_MULH_STEPS)))
    else begin
      $error("valid raised while multiplier busy");
      fail_count++;
    end

  // No register file write while in reset
  no_we_in_reset: assert property (@(posedge clk)
    !rst_n |-> !regfile_we_wb_o)
    else begin
      $error("load write enable set during reset");
      fail_count++;
    end

  // Enable cycle plus one cycle per step, then ready
  mulh_latency: assert property (@(posedge clk) disable iff (!rst_n)
    high_start |-> !ex_ready_o [*(`EX_MULH_STEPS+1)] ##1 ex_ready_o)
    else begin
      $error("high product latency wrong");
      fail_count++;
    end

  // Held instruction keeps its forwarding data
  fw_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ((!ex_ready_o && mult_multicycle_o) || (!wb_ready_i && $past(!wb_ready_i)))
    |-> $stable(regfile_alu_wdata_fw_o))
    else begin
      $error("forwarding data moved during stall");
      fail_count++;
    end

endmodule

bind ex_stage ex_stage_assertions asrt0 (
  .clk                    (clk),
  .rst_n                  (rst_n),
  .ex_valid_o             (ex_valid_o),
  .ex_ready_o             (ex_ready_o),
  .mult_multicycle_o      (mult_multicycle_o),
  .mult_en_i              (mult_en_i),
  .mult_operator_i        (mult_operator_i),
  .branch_in_ex_i         (branch_in_ex_i),
  .wb_ready_i             (wb_ready_i),
  .regfile_we_wb_o        (regfile_we_wb_o),
  .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o)
);

// File: test/ex_stage_tb.sv
// Testbench for the execute stage
// Rows of a stimulus table are driven 2 ns after the rising edge and held
// until ex_ready_o, stall rows are held for two cycles instead
// Expected values come from reference functions, some operands from an LCG
`timescale 1ns/100ps
`include "ex_params.svh"

module ex_stage_tb;

  typedef struct packed {
    logic              alu_en;
    ex_pkg::alu_op_e   alu_op;
    ex_pkg::data_t     a;
    ex_pkg::data_t     b;
    ex_pkg::data_t     c;
    logic              mult_en;
    ex_pkg::mult_op_e  mult_op;
    ex_pkg::data_t     ma;
    ex_pkg::data_t     mb;
    logic              csr;
    ex_pkg::data_t     csr_data;
    logic              alu_we;
    ex_pkg::reg_addr_t alu_waddr;
    logic              we;
    ex_pkg::reg_addr_t waddr;
    logic              lsu_en;
    ex_pkg::data_t     lsu_rdata;
    logic              lsu_ready;
    logic              lsu_err;
    logic              wb_ready;
    logic              branch;
  } row_t;

  logic clk = 1'b0;
  logic rst_n;
  logic alu_en_i, mult_en_i, csr_access_i, lsu_en_i;
  ex_pkg::alu_op_e alu_operator_i;
  ex_pkg::mult_op_e mult_operator_i;
  ex_pkg::data_t alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  ex_pkg::data_t mult_operand_a_i, mult_operand_b_i, csr_rdata_i, lsu_rdata_i;
  logic regfile_alu_we_i, regfile_we_i, lsu_ready_ex_i, lsu_err_i;
  logic branch_in_ex_i, wb_ready_i;
  ex_pkg::reg_addr_t regfile_alu_waddr_i, regfile_waddr_i;
  logic regfile_alu_we_fw_o, regfile_we_wb_o, branch_decision_o;
  logic mult_multicycle_o, ex_ready_o, ex_valid_o;
  ex_pkg::reg_addr_t regfile_alu_waddr_fw_o, regfile_waddr_wb_o;
  ex_pkg::data_t regfile_alu_wdata_fw_o, regfile_wdata_wb_o, jump_target_o;

  row_t rows[$];
  int unsigned lcg_state = 39;
  int cycle_count = 0;
  int cycle_limit = 1000;
  // Model of the EX/WB register
  logic exp_we = 1'b0;
  ex_pkg::reg_addr_t exp_waddr;

  ex_stage dut0 (.*);

  always #10 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, DUT never became ready", cycle_count);
      $display("Some tests failed");
      $fatal(1, "run aborted");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic cmp_ref(ex_pkg::alu_op_e op, ex_pkg::data_t a, ex_pkg::data_t b);
    case (op)
      ex_pkg::ALU_EQ:  return a == b;
      ex_pkg::ALU_NE:  return a != b;
      ex_pkg::ALU_LT:  return $signed(a) < $signed(b);
      ex_pkg::ALU_GE:  return $signed(a) >= $signed(b);
      ex_pkg::ALU_LTU: return a < b;
      ex_pkg::ALU_GEU: return a >= b;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic ex_pkg::data_t alu_ref(ex_pkg::alu_op_e op, ex_pkg::data_t a,
                                            ex_pkg::data_t b);
    case (op)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_SLL:  return a << b[`EX_SHAMT_W-1:0];
      ex_pkg::ALU_SRL:  return a >> b[`EX_SHAMT_W-1:0];
      ex_pkg::ALU_SRA:  return $signed(a) >>> b[`EX_SHAMT_W-1:0];
      ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
      ex_pkg::ALU_SLTU: return (a < b) ? 1 : 0;
      default:          return cmp_ref(op, a, b) ? 1 : 0;
    endcase
  endfunction

  function automatic ex_pkg::data_t mult_ref(ex_pkg::mult_op_e op, ex_pkg::data_t a,
                                             ex_pkg::data_t b);
    logic [2*`EX_DATA_W-1:0] ax;
    logic [2*`EX_DATA_W-1:0] bx;
    logic [2*`EX_DATA_W-1:0] p;
    logic sa;
    logic sb;
    sa = (op == ex_pkg::MUL_H) || (op == ex_pkg::MUL_HSU);
    sb = (op == ex_pkg::MUL_H);
    ax = {{`EX_DATA_W{sa & a[`EX_DATA_W-1]}}, a};
    bx = {{`EX_DATA_W{sb & b[`EX_DATA_W-1]}}, b};
    // Modulo 2^64 product equals the signed one in two's complement
    p = ax * bx;
    return (op == ex_pkg::MUL_LO) ? p[`EX_DATA_W-1:0] : p[2*`EX_DATA_W-1:`EX_DATA_W];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_failure(string what);
    $display("%s at time %0t", what, $time);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(string name, ex_pkg::data_t exp, ex_pkg::data_t act);
    if (exp !== act) begin
      $display("CHECK FAILED time %0t %s expected %h actual %h", $time, name, exp, act);
      report_failure("wrong data value");
    end
  endtask

  task automatic check_addr(string name, ex_pkg::reg_addr_t exp, ex_pkg::reg_addr_t act);
    if (exp !== act) begin
      $display("CHECK FAILED time %0t %s expected %h actual %h", $time, name, exp, act);
      report_failure("wrong register address");
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("CHECK FAILED time %0t %s expected %b actual %b", $time, name, exp, act);
      report_failure("wrong flag");
    end
  endtask

  // Any failed property of the bound checker ends the run
  always @(dut0.asrt0.fail_count) begin
    if (dut0.asrt0.fail_count != 0) begin
      report_failure("protocol assertion failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  function automatic row_t blank_row();
    row_t r;
    r = '0;
    r.alu_op    = ex_pkg::ALU_ADD;
    r.mult_op   = ex_pkg::MUL_LO;
    r.lsu_ready = 1'b1;
    r.wb_ready  = 1'b1;
    r.c         = lcg_next();
    r.lsu_rdata = lcg_next();
    return r;
  endfunction

  function automatic row_t alu_row(int op, ex_pkg::data_t a, ex_pkg::data_t b);
    row_t r;
    r = blank_row();
    r.alu_en = 1'b1;
    r.alu_op = ex_pkg::alu_op_e'(op);
    r.a = a;
    r.b = b;
    r.alu_we = 1'b1;
    r.alu_waddr = ex_pkg::reg_addr_t'(op + 32);
    return r;
  endfunction

  function automatic row_t mult_row(int op, ex_pkg::data_t a, ex_pkg::data_t b);
    row_t r;
    r = blank_row();
    r.mult_en = 1'b1;
    r.mult_op = ex_pkg::mult_op_e'(op);
    r.ma = a;
    r.mb = b;
    r.alu_we = 1'b1;
    r.alu_waddr = ex_pkg::reg_addr_t'(op + 5);
    return r;
  endfunction

  function automatic row_t load_row(ex_pkg::reg_addr_t waddr, logic err, logic lsu_ready);
    row_t r;
    r = blank_row();
    r.lsu_en = 1'b1;
    r.we = 1'b1;
    r.waddr = waddr;
    r.lsu_err = err;
    r.lsu_ready = lsu_ready;
    return r;
  endfunction

  task automatic build_table();
    row_t r;
    for (int i = 0; i < 16; i++) begin
      rows.push_back(alu_row(i, 32'hF000_1234, 32'h0000_0013));
    end
    rows.push_back(alu_row(10, 32'h1234_5678, 32'h1234_5678));
    rows.push_back(alu_row(15, 32'h0000_0001, 32'hFFFF_FFFF));
    for (int i = 0; i < 16; i++) begin
      rows.push_back(alu_row(i, lcg_next(), lcg_next()));
    end
    rows.push_back(mult_row(0, 32'hFFFF_FFFD, 32'h0000_0007));
    rows.push_back(mult_row(1, 32'hFFFF_FFFB, 32'h7FFF_FFFF));
    rows.push_back(mult_row(2, 32'hFFFF_FFFF, 32'hFFFF_FFFF));
    rows.push_back(mult_row(3, 32'hFFFF_FFFF, 32'hFFFF_FFFF));
    for (int i = 0; i < 4; i++) begin
      rows.push_back(mult_row(i, lcg_next(), lcg_next()));
    end
    // CSR over multiplier over ALU
    r = mult_row(0, 32'h0000_0003, 32'h0000_0005);
    r.alu_en = 1'b1;
    r.csr = 1'b1;
    r.csr_data = 32'hC5A0_0001;
    rows.push_back(r);
    // Load port, hold under back-pressure, flush on idle
    rows.push_back(load_row(6'h2A, 1'b0, 1'b1));
    r = blank_row();
    r.wb_ready = 1'b0;
    rows.push_back(r);
    rows.push_back(blank_row());
    rows.push_back(load_row(6'h11, 1'b1, 1'b1));
    rows.push_back(load_row(6'h15, 1'b0, 1'b1));
    rows.push_back(load_row(6'h16, 1'b0, 1'b0));
    // Branch override while WB stalls
    r = alu_row(10, 32'h5, 32'h5);
    r.branch = 1'b1;
    r.wb_ready = 1'b0;
    rows.push_back(r);
    rows.push_back(blank_row());
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Row sequencing
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_row(row_t r);
    alu_en_i = r.alu_en;
    alu_operator_i = r.alu_op;
    alu_operand_a_i = r.a;
    alu_operand_b_i = r.b;
    alu_operand_c_i = r.c;
    mult_en_i = r.mult_en;
    mult_operator_i = r.mult_op;
    mult_operand_a_i = r.ma;
    mult_operand_b_i = r.mb;
    csr_access_i = r.csr;
    csr_rdata_i = r.csr_data;
    regfile_alu_we_i = r.alu_we;
    regfile_alu_waddr_i = r.alu_waddr;
    regfile_we_i = r.we;
    regfile_waddr_i = r.waddr;
    lsu_en_i = r.lsu_en;
    lsu_rdata_i = r.lsu_rdata;
    lsu_ready_ex_i = r.lsu_ready;
    lsu_err_i = r.lsu_err;
    wb_ready_i = r.wb_ready;
    branch_in_ex_i = r.branch;
  endtask

  task automatic check_load(row_t r);
    check_bit("regfile_we_wb_o", exp_we, regfile_we_wb_o);
    if (exp_we) begin
      check_addr("regfile_waddr_wb_o", exp_waddr, regfile_waddr_wb_o);
    end
    check_data("regfile_wdata_wb_o", r.lsu_rdata, regfile_wdata_wb_o);
  endtask

  // Called right at a rising edge, returns at a rising edge
  task automatic run_row(row_t r);
    int waits;
    int exp_waits;
    logic exp_valid;
    ex_pkg::data_t exp_fw;
    #2;
    drive_row(r);
    exp_valid = r.alu_en | r.mult_en | r.csr | r.lsu_en;
    if (!r.wb_ready || !r.lsu_ready) begin
      repeat (2) begin
        @(negedge clk);
        check_bit("ex_ready_o", r.branch, ex_ready_o);
        check_bit("ex_valid_o", 1'b0, ex_valid_o);
        check_load(r);
        @(posedge clk);
        // Stage not valid, WB taking an entry flushes
        if (r.wb_ready) exp_we = 1'b0;
      end
    end else begin
      waits = 0;
      exp_waits = (r.mult_en && r.mult_op != ex_pkg::MUL_LO) ? `EX_MULH_STEPS + 1 : 0;
      @(negedge clk);
      while (!ex_ready_o && waits <= exp_waits) begin
        check_bit("mult_multicycle_o", waits != 0, mult_multicycle_o);
        check_bit("ex_valid_o", 1'b0, ex_valid_o);
        waits++;
        @(posedge clk);
        exp_we = 1'b0;
        @(negedge clk);
      end
      if (waits != exp_waits) begin
        $display("ex_ready_o stayed low %0d cycles, %0d expected", waits, exp_waits);
        report_failure("multiplier latency differs from the expected count");
      end
      if (r.csr) exp_fw = r.csr_data;
      else if (r.mult_en) exp_fw = mult_ref(r.mult_op, r.ma, r.mb);
      else if (r.alu_en) exp_fw = alu_ref(r.alu_op, r.a, r.b);
      else exp_fw = '0;
      check_data("regfile_alu_wdata_fw_o", exp_fw, regfile_alu_wdata_fw_o);
      check_bit("regfile_alu_we_fw_o", r.alu_we, regfile_alu_we_fw_o);
      check_addr("regfile_alu_waddr_fw_o", r.alu_waddr, regfile_alu_waddr_fw_o);
      check_bit("branch_decision_o", cmp_ref(r.alu_op, r.a, r.b), branch_decision_o);
      check_data("jump_target_o", r.c, jump_target_o);
      check_bit("ex_valid_o", exp_valid, ex_valid_o);
      check_bit("mult_multicycle_o", exp_waits != 0, mult_multicycle_o);
      check_load(r);
      @(posedge clk);
      if (exp_valid) begin
        exp_we = r.we & ~r.lsu_err;
        if (exp_we) exp_waddr = r.waddr;
      end else begin
        exp_we = 1'b0;
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    drive_row('0);
    lsu_ready_ex_i = 1'b1;
    wb_ready_i = 1'b1;
    build_table();
    cycle_limit = rows.size() * 4 + 8 + 20;
    repeat (8) @(posedge clk);
    check_bit("regfile_we_wb_o", 1'b0, regfile_we_wb_o);
    check_bit("mult_multicycle_o", 1'b0, mult_multicycle_o);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    @(negedge clk);
    $display("All tests passed");
    $finish;
  end

endmodule

// File: list.f
+incdir+design
design/ex_pkg.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_writeback.sv
design/ex_stage.sv
test/ex_stage_assertions.sv
test/ex_stage_tb.sv
